// File: bootRom.sv
// Word ROM loaded from MEMFILE with address bits 1:0 ignored and data-side writes acked but dropped
`timescale 1ns/1ns
`default_nettype none

module bootRom import memMapPkg::*; (
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire [XLEN-1:0]  i_pcAddr,
    input  wire [XLEN-1:0]  i_wbAdr,
    input  wire             i_wbStb,
    input  wire             i_wbCyc,
    output logic [XLEN-1:0] o_instr,
    output logic [XLEN-1:0] o_wbDatR,
    output logic            o_wbAck
);
    logic [XLEN-1:0]           rom [ROM_WORDS];
    logic [ROM_INDEX_BITS-1:0] pcIndex;
    logic [ROM_INDEX_BITS-1:0] wbIndex;

    initial $readmemh(MEMFILE, rom);

    // Word index from byte address
    assign pcIndex = i_pcAddr[ROM_INDEX_BITS+1:2];
    assign wbIndex = i_wbAdr[ROM_INDEX_BITS+1:2];

    // Fetch port reads every cycle
    // Data port only while strobed
    always_ff @(posedge i_clk) begin
        o_instr <= rom[pcIndex];
        if (i_wbCyc && i_wbStb) begin
            o_wbDatR <= rom[wbIndex];
        end
    end

    // Single-cycle ack that drops while strobe is still held
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wbAck <= 1'b0;
        end else begin
            o_wbAck <= i_wbCyc && i_wbStb && !o_wbAck;
        end
    end

endmodule

`default_nettype wire

// File: busDecoder.sv
// Purely combinational decode and every address maps to exactly one slave so no bus error exists
`timescale 1ns/1ns
`default_nettype none

module busDecoder import memMapPkg::*; (
    input  wire             i_wbStb,
    input  wire [XLEN-1:0]  i_wbAdr,
    input  wire             i_romAck,
    input  wire             i_ramAck,
    input  wire             i_ledAck,
    input  wire [XLEN-1:0]  i_romDat,
    input  wire [XLEN-1:0]  i_ramDat,
    input  wire [XLEN-1:0]  i_ledDat,
    output logic            o_romStb,
    output logic            o_ramStb,
    output logic            o_ledStb,
    output logic            o_wbAck,
    output logic [XLEN-1:0] o_wbDatR
);
    logic selIo;
    logic selRam;
    logic selRom;

    // Region map
    // 0x000-0x1FF ROM, 0x200-0x3FF RAM, 0x3000 LED
    assign selIo  = i_wbAdr[SEL_IO_BIT];
    assign selRam = !selIo && i_wbAdr[SEL_RAM_BIT];
    assign selRom = !selIo && !i_wbAdr[SEL_RAM_BIT];

    // Strobe goes to one slave only
    assign o_romStb = i_wbStb && selRom;
    assign o_ramStb = i_wbStb && selRam;
    assign o_ledStb = i_wbStb && selIo;

    // Return path follows the same select
    always_comb begin
        if (selIo) begin
            o_wbAck  = i_ledAck;
            o_wbDatR = i_ledDat;
        end else if (selRam) begin
            o_wbAck  = i_ramAck;
            o_wbDatR = i_ramDat;
        end else begin
            o_wbAck  = i_romAck;
            o_wbDatR = i_romDat;
        end
    end

endmodule

`default_nettype wire

// File: dataRam.sv
// Word RAM with no reset of contents and address bits 1:0 ignored as only word access exists
`timescale 1ns/1ns
`default_nettype none

module dataRam import memMapPkg::*; (
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire             i_wbCyc,
    input  wire             i_wbStb,
    input  wire             i_wbWe,
    input  wire [XLEN-1:0]  i_wbAdr,
    input  wire [XLEN-1:0]  i_wbDatW,
    output logic [XLEN-1:0] o_wbDatR,
    output logic            o_wbAck
);
    logic [XLEN-1:0]           ram [RAM_WORDS];
    logic [RAM_INDEX_BITS-1:0] index;

    assign index = i_wbAdr[RAM_INDEX_BITS+1:2];

    // Write once on the strobe cycle, read data ready with ack
    always_ff @(posedge i_clk) begin
        if (i_wbCyc && i_wbStb) begin
            if (i_wbWe && !o_wbAck) begin
                ram[index] <= i_wbDatW;
            end
            o_wbDatR <= ram[index];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wbAck <= 1'b0;
        end else begin
            o_wbAck <= i_wbCyc && i_wbStb && !o_wbAck;
        end
    end

endmodule

`default_nettype wire

// File: firmware.mem
// One 32-bit instruction or data word per line, from address 0x000, byte address and assembly after each
00003537 // 000 lui  x10, 0x3         LED base 0x3000
05C00093 // 004 addi x1, x0, 0x5c
03500113 // 008 addi x2, x0, 0x35
002081B3 // 00C add  x3, x1, x2        0x91
00352023 // 010 sw   x3, 0(x10)
402081B3 // 014 sub  x3, x1, x2        0x27
00352023 // 018 sw   x3, 0(x10)
0020F1B3 // 01C and  x3, x1, x2        0x14
00352023 // 020 sw   x3, 0(x10)
0020E1B3 // 024 or   x3, x1, x2        0x7d
00352023 // 028 sw   x3, 0(x10)
0020C1B3 // 02C xor  x3, x1, x2        0x69
00352023 // 030 sw   x3, 0(x10)
20000213 // 034 addi x4, x0, 0x200     RAM base
0A606293 // 038 ori  x5, x0, 0xa6
00522423 // 03C sw   x5, 8(x4)
00822303 // 040 lw   x6, 8(x4)
00652023 // 044 sw   x6, 0(x10)        0xa6
00300393 // 048 addi x7, x0, 3
00752023 // 04C sw   x7, 0(x10)        3, 2, 1
FFF38393 // 050 addi x7, x7, -1
FE039CE3 // 054 bne  x7, x0, -8
0EE00413 // 058 addi x8, x0, 0xee      poison value
00138463 // 05C beq  x7, x1, +8        not taken
008004EF // 060 jal  x9, +8            skips the poison store
00852023 // 064 sw   x8, 0(x10)
00952023 // 068 sw   x9, 0(x10)        link 0x64
00052583 // 06C lw   x11, 0(x10)       LED readback
00158593 // 070 addi x11, x11, 1
00B52023 // 074 sw   x11, 0(x10)       0x65
09402603 // 078 lw   x12, 0x94(x0)     ROM constant
00C52023 // 07C sw   x12, 0(x10)       0xc3
0FF64693 // 080 xori x13, x12, 0xff
00D52023 // 084 sw   x13, 0(x10)       0x3c
00F6F713 // 088 andi x14, x13, 0x0f
00E52023 // 08C sw   x14, 0(x10)       0x0c
0000006F // 090 jal  x0, 0             halt
CAFEF0C3 // 094 constant word

// File: isaPkg.sv
// Encodings cover only the RV32I subset run by the core and hold no shift, compare or system ops
`default_nettype none

package isaPkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // funct3 codes for ALU ops
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    // funct3 codes for branches and word access
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_WORD = 3'b010;
    // funct7 that turns ADD into SUB
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // Internal ALU operation select
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_XOR = 3'd4;

    // One instruction word seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jType;
    } instrT;

endpackage

`default_nettype wire

// File: ledChecker.sv
// Compares each o_led change in order and starts watching at the first reset cycle it sees
`timescale 1ns/1ns
`default_nettype none

module ledChecker import memMapPkg::*; (
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  wire [LED_WIDTH-1:0] i_led,
    input  wire [LED_WIDTH-1:0] i_expNext,
    input  int                  i_expCount,
    output int                  o_seenCount,
    output int                  o_valueErrors,
    output int                  o_extraChanges
);
    logic                 armed = 1'b0;
    logic [LED_WIDTH-1:0] lastLed;

    // Sample on the falling edge, LED register moves on the rising one
    always @(negedge i_clk) begin
        if (!armed) begin
            // First reset cycle gives the starting value
            if (i_rst) begin
                armed          = 1'b1;
                lastLed        = i_led;
                o_seenCount    = 0;
                o_valueErrors  = 0;
                o_extraChanges = 0;
            end
        end else if (i_led !== lastLed) begin
            if (o_seenCount >= i_expCount) begin
                // Nothing left in the expected sequence
                o_extraChanges++;
                $display("LED changed to %02h at %0t ns after the expected sequence ended",
                         i_led, $time);
            end else if (i_led !== i_expNext) begin
                o_valueErrors++;
                $display("** Error o_led expected %02h got %02h (change %0d)",
                         i_expNext, i_led, o_seenCount);
            end
            lastLed = i_led;
            o_seenCount++;
        end
    end

endmodule

`default_nettype wire

// File: ledRegs.sv
// One LED register at any address in the I/O region and only the low LED_WIDTH bits are kept
`timescale 1ns/1ns
`default_nettype none

module ledRegs import memMapPkg::*; (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_wbCyc,
    input  wire                  i_wbStb,
    input  wire                  i_wbWe,
    input  wire [XLEN-1:0]       i_wbDatW,
    output logic [XLEN-1:0]      o_wbDatR,
    output logic                 o_wbAck,
    output logic [LED_WIDTH-1:0] o_led
);
    logic [LED_WIDTH-1:0] ledReg;

    // Readback zero-extended
    assign o_wbDatR = {{(XLEN-LED_WIDTH){1'b0}}, ledReg};
    assign o_led    = ledReg;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ledReg  <= '0;
            o_wbAck <= 1'b0;
        end else begin
            o_wbAck <= i_wbCyc && i_wbStb && !o_wbAck;
            // Commit at the end of the ack cycle while the master still holds data
            if (i_wbCyc && i_wbStb && i_wbWe && o_wbAck) begin
                ledReg <= i_wbDatW[LED_WIDTH-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: memMapPkg.sv
// Address decode looks only at bits 12 and 9 so every address aliases into one of three regions
`default_nettype none

package memMapPkg;

    // Data and address width
    localparam int XLEN = 32;

    // Memory depths in 32-bit words
    localparam int ROM_WORDS      = 128;
    localparam int RAM_WORDS      = 128;
    localparam int ROM_INDEX_BITS = 7;
    localparam int RAM_INDEX_BITS = 7;

    // Region select bits
    // Bit 12 picks I/O, else bit 9 picks RAM over ROM
    localparam int SEL_RAM_BIT = 9;
    localparam int SEL_IO_BIT  = 12;

    // LED register width
    localparam int LED_WIDTH = 8;

    // Program image loaded into the boot ROM
    localparam string MEMFILE = "firmware.mem";

endpackage

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Build and run the smolSoc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_smolSoc -f sources.f

# Run from the project root so firmware.mem and smolStim.txt are found
./obj_dir/Vtb_smolSoc | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: rvCore.sv
// Multi-cycle RV32I subset core where unsupported opcodes or funct3 codes retire as NOPs and nothing traps
`timescale 1ns/1ns
`default_nettype none

module rvCore import memMapPkg::*, isaPkg::*; (
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire [XLEN-1:0]  i_instr,
    input  wire             i_wbAck,
    input  wire [XLEN-1:0]  i_wbDatR,
    output logic [XLEN-1:0] o_pcAddr,
    output logic            o_wbCyc,
    output logic            o_wbStb,
    output logic            o_wbWe,
    output logic [XLEN-1:0] o_wbAdr,
    output logic [XLEN-1:0] o_wbDatW
);
    // Sequencer states
    localparam logic [2:0] ST_FETCH     = 3'd0;
    localparam logic [2:0] ST_DECODE    = 3'd1;
    localparam logic [2:0] ST_EXEC      = 3'd2;
    localparam logic [2:0] ST_MEM       = 3'd3;
    localparam logic [2:0] ST_WRITEBACK = 3'd4;

    logic [2:0]      state;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pcPlus4;
    instrT           fetchWord;
    instrT           instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;

    logic [XLEN-1:0] regFile [32];
    logic [XLEN-1:0] rs1Val;
    logic [XLEN-1:0] rs2Val;
    logic [XLEN-1:0] loadData;
    logic            rdWe;
    logic [XLEN-1:0] rdData;

    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immU;
    logic [XLEN-1:0] immJ;

    logic [2:0]      aluOp;
    logic            aluLegal;
    logic            isSub;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluResult;
    logic            rsEqual;
    logic            brTaken;
    logic            isMemWord;
    logic [XLEN-1:0] memAddr;

    // Fetch address is the PC itself, ROM answers next cycle
    assign o_pcAddr  = pc;
    assign pcPlus4   = pc + XLEN'(4);
    assign fetchWord = i_instr;

    // opcode and funct3 sit at the same bits in every format
    assign opcode = instr.rType.opcode;
    assign funct3 = instr.rType.funct3;

    // Immediates, sign-extended
    assign immI = {{20{instr.iType.imm[11]}}, instr.iType.imm};
    assign immS = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
    assign immB = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                   instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
    assign immU = {instr.uType.imm, 12'b0};
    assign immJ = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19to12,
                   instr.jType.imm11, instr.jType.imm10to1, 1'b0};

    // ALU op select
    // funct7 only matters for register-register ADD/SUB
    assign isSub = (opcode == OP_REG) && (instr.rType.funct7 == F7_SUB);

    always_comb begin
        aluLegal = 1'b1;
        case (funct3)
            F3_ADD:  aluOp = isSub ? ALU_SUB : ALU_ADD;
            F3_XOR:  aluOp = ALU_XOR;
            F3_OR:   aluOp = ALU_OR;
            F3_AND:  aluOp = ALU_AND;
            default: begin
                // Shifts and compares are not implemented
                aluOp    = ALU_ADD;
                aluLegal = 1'b0;
            end
        endcase
    end

    assign aluB = (opcode == OP_REG) ? rs2Val : immI;

    always_comb begin
        case (aluOp)
            ALU_ADD: aluResult = rs1Val + aluB;
            ALU_SUB: aluResult = rs1Val - aluB;
            ALU_AND: aluResult = rs1Val & aluB;
            ALU_OR:  aluResult = rs1Val | aluB;
            ALU_XOR: aluResult = rs1Val ^ aluB;
            default: aluResult = rs1Val + aluB;
        endcase
    end

    // Branch compare, only BEQ and BNE
    assign rsEqual = (rs1Val == rs2Val);
    assign brTaken = ((funct3 == F3_BEQ) && rsEqual) || ((funct3 == F3_BNE) && !rsEqual);

    // Load/store address; byte and halfword widths fall through as NOPs
    assign memAddr   = rs1Val + ((opcode == OP_STORE) ? immS : immI);
    assign isMemWord = (funct3 == F3_WORD);

    // Register write port
    // EXEC for ALU, LUI and JAL results, WRITEBACK for loads
    always_comb begin
        rdWe   = 1'b0;
        rdData = aluResult;
        case (state)
            ST_EXEC: begin
                case (opcode)
                    OP_LUI: begin
                        rdWe   = 1'b1;
                        rdData = immU;
                    end
                    OP_IMM, OP_REG: rdWe = aluLegal;
                    OP_JAL: begin
                        rdWe   = 1'b1;
                        rdData = pcPlus4;
                    end
                    default: rdWe = 1'b0;
                endcase
            end
            ST_WRITEBACK: begin
                rdWe   = 1'b1;
                rdData = loadData;
            end
            default: rdWe = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        // x0 is never written
        if (rdWe && (instr.rType.rd != 5'd0)) begin
            regFile[instr.rType.rd] <= rdData;
        end
    end

    // Datapath registers
    always_ff @(posedge i_clk) begin
        if (state == ST_DECODE) begin
            instr  <= fetchWord;
            // x0 reads as zero regardless of array content
            rs1Val <= (fetchWord.rType.rs1 == 5'd0) ? '0 : regFile[fetchWord.rType.rs1];
            rs2Val <= (fetchWord.rType.rs2 == 5'd0) ? '0 : regFile[fetchWord.rType.rs2];
        end
        // Address and store data held stable through MEM
        if (state == ST_EXEC) begin
            o_wbAdr  <= memAddr;
            o_wbDatW <= rs2Val;
        end
        if ((state == ST_MEM) && i_wbAck) begin
            loadData <= i_wbDatR;
        end
    end

    // Sequencer, PC and bus control
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= ST_FETCH;
            pc      <= '0;
            o_wbCyc <= 1'b0;
            o_wbStb <= 1'b0;
            o_wbWe  <= 1'b0;
        end else begin
            case (state)
                ST_FETCH:  state <= ST_DECODE;
                ST_DECODE: state <= ST_EXEC;
                ST_EXEC: begin
                    state <= ST_FETCH;
                    pc    <= pcPlus4;
                    case (opcode)
                        OP_JAL: pc <= pc + immJ;
                        OP_BRANCH: begin
                            if (brTaken) begin
                                pc <= pc + immB;
                            end
                        end
                        OP_LOAD, OP_STORE: begin
                            // Start one bus transfer
                            if (isMemWord) begin
                                o_wbCyc <= 1'b1;
                                o_wbStb <= 1'b1;
                                o_wbWe  <= (opcode == OP_STORE);
                                state   <= ST_MEM;
                            end
                        end
                        default: state <= ST_FETCH;
                    endcase
                end
                ST_MEM: begin
                    // Stall until the slave acks
                    if (i_wbAck) begin
                        o_wbCyc <= 1'b0;
                        o_wbStb <= 1'b0;
                        o_wbWe  <= 1'b0;
                        state   <= o_wbWe ? ST_FETCH : ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK: state <= ST_FETCH;
                default:      state <= ST_FETCH;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: smolSoc.sv
// Top level with no reset synchronizer so i_rst must already be synchronous to i_clk
`timescale 1ns/1ns
`default_nettype none

module smolSoc import memMapPkg::*; (
    input  wire                  i_clk,
    input  wire                  i_rst,
    output logic [LED_WIDTH-1:0] o_led
);
    // Fetch port
    logic [XLEN-1:0] pcAddr;
    logic [XLEN-1:0] instr;

    // Core side of the data bus
    logic            wbCyc;
    logic            wbStb;
    logic            wbWe;
    logic [XLEN-1:0] wbAdr;
    logic [XLEN-1:0] wbDatW;
    logic [XLEN-1:0] wbDatR;
    logic            wbAck;

    // Per-slave strobe, ack and read data
    logic            romStb;
    logic            ramStb;
    logic            ledStb;
    logic            romAck;
    logic            ramAck;
    logic            ledAck;
    logic [XLEN-1:0] romDat;
    logic [XLEN-1:0] ramDat;
    logic [XLEN-1:0] ledDat;

    rvCore rvCore_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_instr  (instr),
        .i_wbAck  (wbAck),
        .i_wbDatR (wbDatR),
        .o_pcAddr (pcAddr),
        .o_wbCyc  (wbCyc),
        .o_wbStb  (wbStb),
        .o_wbWe   (wbWe),
        .o_wbAdr  (wbAdr),
        .o_wbDatW (wbDatW)
    );

    busDecoder busDecoder_inst (
        .i_wbStb  (wbStb),
        .i_wbAdr  (wbAdr),
        .i_romAck (romAck),
        .i_ramAck (ramAck),
        .i_ledAck (ledAck),
        .i_romDat (romDat),
        .i_ramDat (ramDat),
        .i_ledDat (ledDat),
        .o_romStb (romStb),
        .o_ramStb (ramStb),
        .o_ledStb (ledStb),
        .o_wbAck  (wbAck),
        .o_wbDatR (wbDatR)
    );

    // ROM serves both fetch and constant reads
    bootRom bootRom_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_pcAddr (pcAddr),
        .i_wbAdr  (wbAdr),
        .i_wbStb  (romStb),
        .i_wbCyc  (wbCyc),
        .o_instr  (instr),
        .o_wbDatR (romDat),
        .o_wbAck  (romAck)
    );

    dataRam dataRam_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_wbCyc  (wbCyc),
        .i_wbStb  (ramStb),
        .i_wbWe   (wbWe),
        .i_wbAdr  (wbAdr),
        .i_wbDatW (wbDatW),
        .o_wbDatR (ramDat),
        .o_wbAck  (ramAck)
    );

    ledRegs ledRegs_inst (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_wbCyc  (wbCyc),
        .i_wbStb  (ledStb),
        .i_wbWe   (wbWe),
        .i_wbDatW (wbDatW),
        .o_wbDatR (ledDat),
        .o_wbAck  (ledAck),
        .o_led    (o_led)
    );

endmodule

`default_nettype wire

// File: smolStim.txt
# Columns: command, then a hex LED value for EXPECT
# WAIT holds until every value above it was seen, RESET pulses i_rst for 2 cycles
# ALU results of ADD SUB AND OR XOR
EXPECT 91
EXPECT 27
EXPECT 14
EXPECT 7D
EXPECT 69
# RAM round trip
EXPECT A6
# Countdown loop, cut short by a reset
EXPECT 03
EXPECT 02
WAIT
RESET
EXPECT 00
# Whole sequence again from the reset vector
EXPECT 91
EXPECT 27
EXPECT 14
EXPECT 7D
EXPECT 69
EXPECT A6
EXPECT 03
EXPECT 02
EXPECT 01
# JAL link address, then LED readback plus one
EXPECT 64
EXPECT 65
# ROM constant low byte, then XORI and ANDI on it
EXPECT C3
EXPECT 3C
EXPECT 0C

// File: sources.f
memMapPkg.sv
isaPkg.sv
bootRom.sv
dataRam.sv
ledRegs.sv
busDecoder.sv
rvCore.sv
smolSoc.sv
ledChecker.sv
tb_smolSoc.sv

// File: tb_smolSoc.sv
// Reads smolStim.txt from the run directory and holds at most 64 commands
`timescale 1ns/1ns
`default_nettype none

module tb_smolSoc import memMapPkg::*; ();
    localparam int CLK_PERIOD        = 100;
    localparam int MAX_STEPS         = 64;
    localparam int CYCLES_PER_EXPECT = 400;
    // Command codes
    localparam int CMD_EXPECT = 0;
    localparam int CMD_WAIT   = 1;
    localparam int CMD_RESET  = 2;

    // Clock starts low with no edge at time 0
    logic                 clk = 1'b0;
    logic                 rst;
    logic [LED_WIDTH-1:0] led;

    // Parsed stimulus
    int                   cmdKind  [MAX_STEPS];
    int                   cmdCount;
    logic [LED_WIDTH-1:0] expTable [MAX_STEPS];
    int                   expCount;
    logic [LED_WIDTH-1:0] expNext;

    // Checker results
    int seenCount;
    int valueErrors;
    int extraChanges;

    bit fileOk   = 1'b0;
    bit loaded   = 1'b0;
    bit timedOut = 1'b0;

    // Next value the checker should see
    assign expNext = (seenCount < expCount) ? expTable[seenCount] : '0;

    smolSoc smolSoc_inst (
        .i_clk (clk),
        .i_rst (rst),
        .o_led (led)
    );

    ledChecker ledChecker_inst (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_led          (led),
        .i_expNext      (expNext),
        .i_expCount     (expCount),
        .o_seenCount    (seenCount),
        .o_valueErrors  (valueErrors),
        .o_extraChanges (extraChanges)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic loadStimulus();
        int    fd;
        int    n;
        int    value;
        string line;
        string word;
        cmdCount = 0;
        expCount = 0;
        fd = $fopen("smolStim.txt", "r");
        fileOk = (fd != 0);
        if (fileOk) begin
            while (!$feof(fd)) begin
                line = "";
                word = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %h", word, value);
                // Comment and blank lines match no command
                if (cmdCount >= MAX_STEPS) begin
                    $display("Stimulus file holds more than %0d commands", MAX_STEPS);
                    fileOk = 1'b0;
                end else if (word == "EXPECT" && n == 2) begin
                    cmdKind[cmdCount]  = CMD_EXPECT;
                    expTable[expCount] = value[LED_WIDTH-1:0];
                    cmdCount++;
                    expCount++;
                end else if (word == "WAIT") begin
                    cmdKind[cmdCount] = CMD_WAIT;
                    cmdCount++;
                end else if (word == "RESET") begin
                    cmdKind[cmdCount] = CMD_RESET;
                    cmdCount++;
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    // Reset pulse of 2 cycles driven just after a rising edge
    task automatic pulseReset();
        @(posedge clk);
        #5 rst = 1'b1;
        repeat (2) @(posedge clk);
        #5 rst = 1'b0;
    endtask

    task automatic runCommands();
        int expSoFar;
        expSoFar = 0;
        for (int i = 0; i < cmdCount; i++) begin
            case (cmdKind[i])
                CMD_EXPECT: expSoFar++;
                CMD_WAIT:   wait (seenCount >= expSoFar);
                CMD_RESET:  pulseReset();
                default:    expSoFar = expSoFar;
            endcase
        end
    endtask

    task automatic endRun();
        int missing;
        int errors;
        missing = (seenCount < expCount) ? expCount - seenCount : 0;
        errors  = valueErrors + extraChanges + missing;
        if (missing > 0) begin
            $display("%0d expected LED values never appeared", missing);
        end
        $display("Errors: %0d wrong values, %0d unexpected changes, %0d missing, %0d of %0d seen",
                 valueErrors, extraChanges, missing, seenCount, expCount);
        if (errors == 0 && fileOk && !timedOut) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // Main sequence
    initial begin
        rst = 1'b1;
        loadStimulus();
        if (!fileOk) begin
            $display("Could not read the stimulus file smolStim.txt");
            endRun();
        end else begin
            repeat (2) @(posedge clk);
            #5 rst = 1'b0;
            runCommands();
            wait (seenCount >= expCount);
            // Idle time to catch stray LED writes after the last value
            repeat (50) @(posedge clk);
            endRun();
        end
    end

    // Watchdog sized at 400 cycles per expected value
    initial begin
        longint limitNs;
        wait (loaded && fileOk);
        limitNs = longint'(expCount) * longint'(CYCLES_PER_EXPECT) * longint'(CLK_PERIOD);
        #(limitNs);
        timedOut = 1'b1;
        $display("Timeout: LED sequence stalled after %0d of %0d values", seenCount, expCount);
        endRun();
    end

endmodule

`default_nettype wire
